//--- build.f
rtl/piPkg.sv
rtl/conoPkg.sv
rtl/piLevelArbiter.sv
rtl/piDeviceSelect.sv
rtl/piCycleSequencer.sv
rtl/piController.sv
testbench/tbClock.sv
testbench/tbPiController.sv

//--- rtl/conoPkg.sv
package conoPkg;

  localparam int wordWidth = 18;  // CONO and CONI word width

  // CONO PI function bits
  localparam int conoGenClr   = 4;
  localparam int conoSysClr   = 5;
  localparam int conoGenSet   = 6;
  localparam int conoOnSet    = 7;
  localparam int conoOnClr    = 8;
  localparam int conoOff      = 9;
  localparam int conoOn       = 10;
  localparam int conoLevelLsb = 11;  // Level n sits at bit n+10

  // PIA field of CONO APR and CONO MTR
  localparam int conoPiaLsb = 15;
  localparam int piaWidth   = 3;

  // CONI PI status word
  localparam int statHoldLsb = 3;
  localparam int statActive  = 10;
  localparam int statOnLsb   = 11;

endpackage

//--- rtl/piController.sv
`timescale 1ns/10ps

module piController #(
  parameter int numLevels = piPkg::levelCount
) (
  input  logic                          clk,
  input  logic                          TIM,
  input  logic                          conoPi,
  input  logic                          conoApr,
  input  logic                          conoMtr,
  input  logic [conoPkg::wordWidth-1:0] conoData,
  input  logic [numLevels:1]            ioReq,
  input  logic                          aprInterrupt,
  input  logic                          mtrInterrupt,
  input  logic                          piDisable,
  input  logic                          dismiss,
  output logic                          piCycle,
  output logic [piPkg::levelWidth-1:0]  piLevel,
  output piPkg::piSource                piSrc,
  output logic                          vectorValid,
  output logic [piPkg::levelWidth-1:0]  holdLevel,
  output logic [conoPkg::wordWidth-1:0] coniData
);
  import piPkg::*;

  logic                  reqValid;
  logic [levelWidth-1:0] reqLevel;
  logic                  reqGen;
  logic [numLevels:1]    internalReq;
  piSource               matchSrc;
  logic                  setHold;
  logic [levelWidth-1:0] grantLevel;

  piLevelArbiter #(.numLevels(numLevels)) iArbiter (
    .clk         (clk),
    .TIM         (TIM),
    .conoPi      (conoPi),
    .conoData    (conoData),
    .ioReq       (ioReq),
    .internalReq (internalReq),
    .setHold     (setHold),
    .grantLevel  (grantLevel),
    .dismiss     (dismiss),
    .reqValid    (reqValid),
    .reqLevel    (reqLevel),
    .reqGen      (reqGen),
    .holdLevel   (holdLevel),
    .coniData    (coniData)
  );

  piDeviceSelect #(.numLevels(numLevels)) iDevSelect (
    .clk          (clk),
    .TIM          (TIM),
    .conoApr      (conoApr),
    .conoMtr      (conoMtr),
    .conoData     (conoData),
    .aprInterrupt (aprInterrupt),
    .mtrInterrupt (mtrInterrupt),
    .reqLevel     (reqLevel),
    .internalReq  (internalReq),
    .matchSrc     (matchSrc)
  );

  piCycleSequencer #(.numLevels(numLevels)) iSequencer (
    .clk         (clk),
    .TIM         (TIM),
    .reqValid    (reqValid),
    .reqLevel    (reqLevel),
    .reqGen      (reqGen),
    .matchSrc    (matchSrc),
    .piDisable   (piDisable),
    .piCycle     (piCycle),
    .piLevel     (piLevel),
    .piSrc       (piSrc),
    .vectorValid (vectorValid),
    .setHold     (setHold),
    .grantLevel  (grantLevel)
  );

endmodule

//--- rtl/piCycleSequencer.sv
`timescale 1ns/10ps

module piCycleSequencer #(
  parameter int numLevels = piPkg::levelCount
) (
  input  logic                         clk,
  input  logic                         TIM,
  input  logic                         reqValid,
  input  logic [piPkg::levelWidth-1:0] reqLevel,
  input  logic                         reqGen,
  input  piPkg::piSource               matchSrc,
  input  logic                         piDisable,
  output logic                         piCycle,
  output logic [piPkg::levelWidth-1:0] piLevel,
  output piPkg::piSource               piSrc,
  output logic                         vectorValid,
  output logic                         setHold,
  output logic [piPkg::levelWidth-1:0] grantLevel
);
  import piPkg::*;

  seqState state;
  seqState stateNext;
  piSource srcPick;
  logic    startCycle;

  // Ignore level numbers beyond what this controller was built with
  assign startCycle = reqValid & ~piDisable & (reqLevel != '0) &
                      (int'(reqLevel) <= numLevels);

  // Internal device answer first, then software generate, else the bus
  always_comb begin
    if (matchSrc != srcExternal)
      srcPick = matchSrc;
    else if (reqGen)
      srcPick = srcGen;
    else
      srcPick = srcExternal;
  end

  always_comb begin
    stateNext = state;
    case (state)
      stIdle: begin
        if (startCycle)
          stateNext = stGrant;
      end
      stGrant:  stateNext = stVector;
      stVector: stateNext = stSettle;
      stSettle: stateNext = stIdle;  // New hold bit reaches reqLevel here
      default:  stateNext = stIdle;
    endcase
  end

  always_ff @(posedge clk or posedge TIM) begin
    if (TIM) begin
      state      <= stIdle;
      grantLevel <= '0;
      piSrc      <= srcExternal;
    end else begin
      state <= stateNext;
      if (state == stIdle && startCycle) begin
        grantLevel <= reqLevel;
        piSrc      <= srcPick;
      end
    end
  end

  assign piCycle     = (state == stGrant) || (state == stVector);
  assign vectorValid = (state == stVector);
  assign setHold     = (state == stVector);  // Hold bit set as the vector goes out
  assign piLevel     = grantLevel;

endmodule

//--- rtl/piDeviceSelect.sv
`timescale 1ns/10ps

module piDeviceSelect #(
  parameter int numLevels = piPkg::levelCount
) (
  input  logic                          clk,
  input  logic                          TIM,
  input  logic                          conoApr,
  input  logic                          conoMtr,
  input  logic [conoPkg::wordWidth-1:0] conoData,
  input  logic                          aprInterrupt,
  input  logic                          mtrInterrupt,
  input  logic [piPkg::levelWidth-1:0]  reqLevel,
  output logic [numLevels:1]            internalReq,
  output piPkg::piSource                matchSrc
);
  import piPkg::*;
  import conoPkg::*;

  logic [piaWidth-1:0] aprPia;
  logic [piaWidth-1:0] mtrPia;
  logic [numLevels:1]  aprReq;
  logic [numLevels:1]  mtrReq;
  logic                aprMatch;
  logic                mtrMatch;

  always_ff @(posedge clk or posedge TIM) begin
    if (TIM) begin
      aprPia <= '0;
      mtrPia <= '0;
    end else begin
      if (conoApr)
        aprPia <= conoData[conoPiaLsb +: piaWidth];
      if (conoMtr)
        mtrPia <= conoData[conoPiaLsb +: piaWidth];
    end
  end

  // One-hot level per source; PIA 0 never matches a level
  always_comb begin
    for (int n = 1; n <= numLevels; n++) begin
      aprReq[n] = aprInterrupt & (aprPia == piaWidth'(n));
      mtrReq[n] = mtrInterrupt & (mtrPia == piaWidth'(n));
    end
  end

  assign internalReq = aprReq | mtrReq;

  assign aprMatch = aprInterrupt & (aprPia != '0) & (levelWidth'(aprPia) == reqLevel);
  assign mtrMatch = mtrInterrupt & (mtrPia != '0) & (levelWidth'(mtrPia) == reqLevel);

  always_comb begin
    if (aprMatch)
      matchSrc = srcApr;       // APR answers first on a shared level
    else if (mtrMatch)
      matchSrc = srcMtr;
    else
      matchSrc = srcExternal;
  end

endmodule

//--- rtl/piLevelArbiter.sv
`timescale 1ns/10ps

module piLevelArbiter #(
  parameter int numLevels = piPkg::levelCount
) (
  input  logic                          clk,
  input  logic                          TIM,
  input  logic                          conoPi,
  input  logic [conoPkg::wordWidth-1:0] conoData,
  input  logic [numLevels:1]            ioReq,
  input  logic [numLevels:1]            internalReq,
  input  logic                          setHold,
  input  logic [piPkg::levelWidth-1:0]  grantLevel,
  input  logic                          dismiss,
  output logic                          reqValid,
  output logic [piPkg::levelWidth-1:0]  reqLevel,
  output logic                          reqGen,
  output logic [piPkg::levelWidth-1:0]  holdLevel,
  output logic [conoPkg::wordWidth-1:0] coniData
);
  import piPkg::*;
  import conoPkg::*;

  logic [numLevels:1]    onBits;
  logic [numLevels:1]    genBits;
  logic [numLevels:1]    holdBits;
  logic                  active;
  logic [numLevels:1]    levelSel;    // Level select field of the CONO word
  logic [numLevels:1]    requesting;
  logic [numLevels:1]    holdNext;
  logic [levelWidth-1:0] nextLevel;
  logic                  nextGen;
  logic                  sysClr;

  assign sysClr = conoPi & conoData[conoSysClr];

  always_comb begin
    for (int n = 1; n <= numLevels; n++) begin
      levelSel[n]   = conoData[conoLevelLsb + n - 1];
      requesting[n] = active & (genBits[n] | onBits[n] & (ioReq[n] | internalReq[n]));
    end
  end

  // Highest-priority level currently held
  always_comb begin
    holdLevel = '0;
    for (int n = numLevels; n >= 1; n--) begin
      if (holdBits[n])
        holdLevel = levelWidth'(n);
    end
  end

  // Only a level above everything in progress may interrupt
  always_comb begin
    int limit;
    limit     = (holdLevel == '0) ? numLevels + 1 : int'(holdLevel);
    nextLevel = '0;
    nextGen   = 1'b0;
    for (int n = numLevels; n >= 1; n--) begin
      if (requesting[n] && n < limit) begin
        nextLevel = levelWidth'(n);
        nextGen   = genBits[n];
      end
    end
  end

  always_comb begin
    holdNext = holdBits;
    for (int n = 1; n <= numLevels; n++) begin
      if (dismiss && holdLevel == levelWidth'(n))
        holdNext[n] = 1'b0;
      if (setHold && grantLevel == levelWidth'(n))
        holdNext[n] = 1'b1;
    end
  end

  always_ff @(posedge clk or posedge TIM) begin
    if (TIM) begin
      onBits   <= '0;
      genBits  <= '0;
      holdBits <= '0;
      active   <= 1'b0;
      reqLevel <= '0;
      reqValid <= 1'b0;
      reqGen   <= 1'b0;
    end else if (sysClr) begin
      onBits   <= '0;
      genBits  <= '0;
      holdBits <= '0;
      active   <= 1'b0;
      reqLevel <= '0;
      reqValid <= 1'b0;
      reqGen   <= 1'b0;
    end else begin
      holdBits <= holdNext;
      reqLevel <= nextLevel;
      reqValid <= (nextLevel != '0);
      reqGen   <= nextGen;
      if (conoPi) begin
        onBits  <= (onBits & ~({numLevels{conoData[conoOnClr]}} & levelSel)) |
                   ({numLevels{conoData[conoOnSet]}} & levelSel);
        genBits <= (genBits & ~({numLevels{conoData[conoGenClr]}} & levelSel)) |
                   ({numLevels{conoData[conoGenSet]}} & levelSel);
        if (conoData[conoOn])
          active <= 1'b1;  // Turning on wins over off
        else if (conoData[conoOff])
          active <= 1'b0;
      end
    end
  end

  always_comb begin
    coniData             = '0;
    coniData[statActive] = active;
    for (int n = 1; n <= numLevels; n++) begin
      coniData[statHoldLsb + n - 1] = holdBits[n];
      coniData[statOnLsb + n - 1]   = onBits[n];
    end
  end

endmodule

//--- rtl/piPkg.sv
package piPkg;

  // Levels are numbered 1 (highest priority) to 7
  localparam int levelCount = 7;

  // Width of a level number, 0 means no level
  localparam int levelWidth = 3;

  // Who answers an interrupt cycle
  typedef enum logic [1:0] {
    srcExternal = 2'd0,
    srcGen      = 2'd1,
    srcApr      = 2'd2,
    srcMtr      = 2'd3
  } piSource;

  // Interrupt cycle sequencer states
  typedef enum logic [1:0] {
    stIdle   = 2'd0,
    stGrant  = 2'd1,
    stVector = 2'd2,
    stSettle = 2'd3
  } seqState;

endpackage

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir sim.log

verilator --binary --timing --timescale 1ns/10ps -f build.f \
  --top-module tbPiController -o simPi
./obj_dir/simPi > sim.log
cat sim.log

if grep -q "^Everything OK$" sim.log; then
  echo "Simulation run passed"
else
  echo "Simulation run did not pass"
  exit 1
fi

//--- testbench/tbClock.sv
`timescale 1ns/10ps

module tbClock #(
  parameter int halfPeriod = 4  // 8 ns period
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
  end

  always #(halfPeriod) clk = ~clk;

endmodule

//--- testbench/tbPiController.sv
`timescale 1ns/10ps

module tbPiController;
  import piPkg::*;
  import conoPkg::*;

  typedef enum logic [2:0] {opCono, opApr, opMtr, opRequest, opDismiss, opDisable} rowOp;

  typedef struct packed {
    rowOp                  op;
    logic [wordWidth-1:0]  data;
    logic                  expVec;
    logic [levelWidth-1:0] expLevel;
    piSource               expSrc;
    logic [levelWidth-1:0] expHold;
  } stimRow;

  localparam int maxRows = 64;

  logic                  clk;
  logic                  TIM;
  logic                  conoPi;
  logic                  conoApr;
  logic                  conoMtr;
  logic [wordWidth-1:0]  conoData;
  logic [levelCount:1]   ioReq;
  logic                  aprInterrupt;
  logic                  mtrInterrupt;
  logic                  piDisable;
  logic                  dismiss;
  logic                  piCycle;
  logic [levelWidth-1:0] piLevel;
  piSource               piSrc;
  logic                  vectorValid;
  logic [levelWidth-1:0] holdLevel;
  logic [wordWidth-1:0]  coniData;

  stimRow              rows [maxRows];
  int                  rowCount;
  bit                  tableReady;
  int                  passCount;
  int                  failCount;
  int                  seed;
  logic [levelCount:1] modelOn;    // Reference copy of the on, hold and active state
  logic [levelCount:1] modelHold;
  logic                modelActive;

  tbClock clockGen (.clk(clk));

  piController #(.numLevels(levelCount)) i_dut (
    .clk          (clk),
    .TIM          (TIM),
    .conoPi       (conoPi),
    .conoApr      (conoApr),
    .conoMtr      (conoMtr),
    .conoData     (conoData),
    .ioReq        (ioReq),
    .aprInterrupt (aprInterrupt),
    .mtrInterrupt (mtrInterrupt),
    .piDisable    (piDisable),
    .dismiss      (dismiss),
    .piCycle      (piCycle),
    .piLevel      (piLevel),
    .piSrc        (piSrc),
    .vectorValid  (vectorValid),
    .holdLevel    (holdLevel),
    .coniData     (coniData)
  );

  function automatic logic [wordWidth-1:0] conoBit(input int pos);
    logic [wordWidth-1:0] w;
    w      = '0;
    w[pos] = 1'b1;
    return w;
  endfunction

  function automatic logic [levelCount:1] levelMask(input int n);
    logic [levelCount:1] m;
    m    = '0;
    m[n] = 1'b1;
    return m;
  endfunction

  function automatic logic [wordWidth-1:0] levelField(input logic [levelCount:1] m);
    logic [wordWidth-1:0] w;
    w                              = '0;
    w[conoLevelLsb +: levelCount] = m;
    return w;
  endfunction

  function automatic logic [wordWidth-1:0] piaWord(input int pia);
    logic [wordWidth-1:0] w;
    w                           = '0;
    w[conoPiaLsb +: piaWidth] = piaWidth'(pia);
    return w;
  endfunction

  // Request row data: ioReq in the low bits, then APR and MTR lines
  function automatic logic [wordWidth-1:0] reqWord(input logic [levelCount:1] m,
                                                   input logic apr, input logic mtr);
    logic [wordWidth-1:0] w;
    w                   = '0;
    w[levelCount-1:0]   = m;
    w[levelCount]       = apr;
    w[levelCount + 1]   = mtr;
    return w;
  endfunction

  // Priority rule: level 1 wins
  function automatic int lowestLevel(input logic [levelCount:1] m);
    int lvl;
    lvl = 0;
    for (int n = 1; n <= levelCount; n++) begin
      if (m[n] && lvl == 0)
        lvl = n;
    end
    return lvl;
  endfunction

  function automatic logic [wordWidth-1:0] statusWord();
    logic [wordWidth-1:0] w;
    w                              = '0;
    w[statHoldLsb +: levelCount]  = modelHold;
    w[statActive]                 = modelActive;
    w[statOnLsb +: levelCount]    = modelOn;
    return w;
  endfunction

  task automatic addRow(input rowOp op, input logic [wordWidth-1:0] data, input logic expVec,
                        input int expLevel, input piSource expSrc, input int expHold);
    rows[rowCount].op       = op;
    rows[rowCount].data     = data;
    rows[rowCount].expVec   = expVec;
    rows[rowCount].expLevel = levelWidth'(expLevel);
    rows[rowCount].expSrc   = expSrc;
    rows[rowCount].expHold  = levelWidth'(expHold);
    rowCount++;
  endtask

  task automatic buildTable();
    logic [levelCount:1] mask;
    int                  lvl;
    addRow(opCono, conoBit(conoOn) | conoBit(conoOnSet) | levelField('1), 1'b0, 0,
           srcExternal, 0);
    for (int k = 0; k < 4; k++) begin
      mask = levelCount'($random(seed));
      if (mask == '0)
        mask = levelMask(levelCount);
      lvl = lowestLevel(mask);
      addRow(opRequest, reqWord(mask, 1'b0, 1'b0), 1'b1, lvl, srcExternal, lvl);
      addRow(opRequest, reqWord('0, 1'b0, 1'b0), 1'b0, 0, srcExternal, lvl);
      addRow(opDismiss, '0, 1'b0, 0, srcExternal, 0);
    end
    // Lower priority than the held level waits for dismiss
    addRow(opRequest, reqWord(levelMask(3), 1'b0, 1'b0), 1'b1, 3, srcExternal, 3);
    addRow(opRequest, reqWord(levelMask(6), 1'b0, 1'b0), 1'b0, 0, srcExternal, 3);
    addRow(opDismiss, '0, 1'b1, 6, srcExternal, 6);
    addRow(opRequest, reqWord('0, 1'b0, 1'b0), 1'b0, 0, srcExternal, 6);
    addRow(opDismiss, '0, 1'b0, 0, srcExternal, 0);
    addRow(opCono, conoBit(conoOnClr) | levelField(levelMask(4)), 1'b0, 0, srcExternal, 0);
    addRow(opCono, conoBit(conoGenSet) | levelField(levelMask(4)), 1'b1, 4, srcGen, 4);
    addRow(opCono, conoBit(conoGenClr) | levelField(levelMask(4)), 1'b0, 0, srcExternal, 4);
    addRow(opDismiss, '0, 1'b0, 0, srcExternal, 0);
    addRow(opCono, conoBit(conoOnSet) | levelField(levelMask(4)), 1'b0, 0, srcExternal, 0);
    addRow(opApr, piaWord(2), 1'b0, 0, srcExternal, 0);
    addRow(opMtr, piaWord(2), 1'b0, 0, srcExternal, 0);
    addRow(opRequest, reqWord('0, 1'b1, 1'b1), 1'b1, 2, srcApr, 2);
    addRow(opRequest, reqWord('0, 1'b0, 1'b0), 1'b0, 0, srcExternal, 2);
    addRow(opDismiss, '0, 1'b0, 0, srcExternal, 0);
    addRow(opApr, piaWord(0), 1'b0, 0, srcExternal, 0);
    addRow(opRequest, reqWord('0, 1'b1, 1'b1), 1'b1, 2, srcMtr, 2);
    addRow(opRequest, reqWord('0, 1'b0, 1'b0), 1'b0, 0, srcExternal, 2);
    addRow(opDismiss, '0, 1'b0, 0, srcExternal, 0);
    addRow(opDisable, 18'd1, 1'b0, 0, srcExternal, 0);
    addRow(opRequest, reqWord(levelMask(1), 1'b0, 1'b0), 1'b0, 0, srcExternal, 0);
    addRow(opCono, conoBit(conoSysClr), 1'b0, 0, srcExternal, 0);
    addRow(opDisable, 18'd0, 1'b0, 0, srcExternal, 0);  // System is off now
    addRow(opRequest, reqWord('0, 1'b0, 1'b0), 1'b0, 0, srcExternal, 0);
  endtask

  task automatic driveRow(input stimRow r);
    @(posedge clk);
    case (r.op)
      opCono: begin
        conoPi   <= 1'b1;
        conoData <= r.data;
      end
      opApr: begin
        conoApr  <= 1'b1;
        conoData <= r.data;
      end
      opMtr: begin
        conoMtr  <= 1'b1;
        conoData <= r.data;
      end
      opRequest: begin
        ioReq        <= r.data[levelCount-1:0];
        aprInterrupt <= r.data[levelCount];
        mtrInterrupt <= r.data[levelCount + 1];
      end
      opDismiss: dismiss   <= 1'b1;
      opDisable: piDisable <= r.data[0];
      default: ;
    endcase
    @(posedge clk);
    conoPi  <= 1'b0;  // Strobes last one cycle
    conoApr <= 1'b0;
    conoMtr <= 1'b0;
    dismiss <= 1'b0;
  endtask

  task automatic updateModel(input stimRow r);
    logic [levelCount:1] sel;
    logic                done;
    sel  = r.data[conoLevelLsb +: levelCount];
    done = 1'b0;
    if (r.op == opCono && r.data[conoSysClr]) begin
      modelOn     = '0;
      modelHold   = '0;
      modelActive = 1'b0;
    end else if (r.op == opCono) begin
      if (r.data[conoOnClr])
        modelOn = modelOn & ~sel;
      if (r.data[conoOnSet])
        modelOn = modelOn | sel;
      if (r.data[conoOn])
        modelActive = 1'b1;
      else if (r.data[conoOff])
        modelActive = 1'b0;
    end else if (r.op == opDismiss) begin
      for (int n = 1; n <= levelCount; n++) begin
        if (modelHold[n] && !done) begin
          modelHold[n] = 1'b0;
          done         = 1'b1;
        end
      end
    end
    if (r.expVec)
      modelHold[r.expLevel] = 1'b1;  // Dismiss first, then the new grant
  endtask

  task automatic runRow(input int idx);
    stimRow                r;
    rowOp                  op;
    logic                  found;
    logic [levelWidth-1:0] gotLevel;
    piSource               gotSrc;
    logic [wordWidth-1:0]  expConi;
    int                    errs;
    int                    cycleHigh;
    int                    expCycles;
    r         = rows[idx];
    op        = r.op;
    found     = 1'b0;
    gotLevel  = '0;
    gotSrc    = srcExternal;
    errs      = 0;
    cycleHigh = 0;
    expCycles = r.expVec ? 2 : 0;  // Grant and vector cycles
    driveRow(r);
    for (int c = 0; c < 10 && !found; c++) begin
      @(negedge clk);
      if (piCycle)
        cycleHigh++;
      if (vectorValid) begin
        found    = 1'b1;
        gotLevel = piLevel;
        gotSrc   = piSrc;
      end
    end
    for (int c = 0; c < 3; c++) begin  // Let the hold bit land
      @(negedge clk);
      if (piCycle)
        cycleHigh++;
    end
    updateModel(r);
    expConi = statusWord();
    if (r.expVec && !found) begin
      $display("Row %0d: expected an interrupt vector but none came in 10 cycles", idx);
      errs++;
    end
    if (!r.expVec && found) begin
      $display("Row %0d: unexpected interrupt vector for level %0d", idx, gotLevel);
      errs++;
    end
    if (r.expVec && found && gotLevel != r.expLevel) begin
      $display("Error row %0d: piLevel expected %h got %h", idx, r.expLevel, gotLevel);
      errs++;
    end
    if (r.expVec && found && gotSrc != r.expSrc) begin
      $display("Error row %0d: piSrc expected %h got %h", idx, r.expSrc, gotSrc);
      errs++;
    end
    if (cycleHigh != expCycles) begin
      $display("Error row %0d: piCycle high cycles expected %h got %h", idx, expCycles,
               cycleHigh);
      errs++;
    end
    if (holdLevel != r.expHold) begin
      $display("Error row %0d: holdLevel expected %h got %h", idx, r.expHold, holdLevel);
      errs++;
    end
    if (coniData != expConi) begin
      $display("Error row %0d: coniData expected %h got %h", idx, expConi, coniData);
      errs++;
    end
    if (errs == 0) begin
      passCount++;
      $display("Row %0d %s: ok", idx, op.name());
    end else begin
      failCount++;
      $display("Row %0d %s: %0d problem(s)", idx, op.name(), errs);
    end
  endtask

  initial begin
    TIM          <= 1'b1;
    conoPi       <= 1'b0;
    conoApr      <= 1'b0;
    conoMtr      <= 1'b0;
    conoData     <= '0;
    ioReq        <= '0;
    aprInterrupt <= 1'b0;
    mtrInterrupt <= 1'b0;
    piDisable    <= 1'b0;
    dismiss      <= 1'b0;
    modelOn      = '0;
    modelHold    = '0;
    modelActive  = 1'b0;
    passCount    = 0;
    failCount    = 0;
    rowCount     = 0;
    seed         = 32'h3019_88bd;
    buildTable();
    tableReady = 1'b1;
    repeat (16) @(posedge clk);
    TIM <= 1'b0;
    repeat (2) @(posedge clk);
    for (int i = 0; i < rowCount; i++)
      runRow(i);
    $display("Rows run %0d, passed %0d, failed %0d", rowCount, passCount, failCount);
    if (failCount == 0)
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  end

  // 40 cycles of 8 ns per row
  initial begin
    wait (tableReady);
    #(rowCount * 40 * 8);
    $display("Watchdog expired before all %0d rows were run", rowCount);
    $display("Something failed");
    $finish;
  end

endmodule
